// ==== logic/apb_req_decoder.sv ====
`timescale 1ns/10ps

module apb_req_decoder
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [PADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0]  pwdata,
  input  logic [STRB_W-1:0]  pstrb,
  input  logic               pready,
  output logic               op_valid,
  output cache_op_e          op,
  output logic [SET_W-1:0]   set_idx,
  output logic [TAG_W-1:0]   tag,
  output logic [DATA_W-1:0]  wdata,
  output logic [STRB_W-1:0]  strb
);

  apb_phase_e state;
  logic       issue;
  cache_op_e  next_op;

  // first access cycle only, later access cycles of the same transfer are ignored
  assign issue = (state == ph_idle) && psel && penable;

  always_comb begin
    if (!pwrite) begin
      next_op = op_read; // fill bit is don't care on reads
    end else if (paddr[FILL_BIT]) begin
      next_op = op_fill;
    end else begin
      next_op = op_write;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ph_idle;
    end else begin
      case (state)
        ph_idle: begin
          if (issue) state <= ph_issued;
        end
        ph_issued: begin
          state <= ph_wait;
        end
        ph_wait: begin
          if (pready) state <= ph_idle; // response cycle closes the transfer
        end
        default: begin
          state <= ph_idle;
        end
      endcase
    end
  end

  // operation fields, held until the next transfer
  always_ff @(posedge clk) begin
    if (issue) begin
      op      <= next_op;
      set_idx <= paddr[SET_LSB +: SET_W];
      tag     <= paddr[TAG_LSB +: TAG_W];
      wdata   <= pwdata;
      strb    <= pstrb;
    end
  end

  assign op_valid = (state == ph_issued);

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

  // word and bus widths
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;
  localparam int PADDR_W = 12;

  // address split: [9:6] tag, [5:2] set
  localparam int SET_W    = 4;
  localparam int SET_LSB  = 2;
  localparam int NUM_SETS = 1 << SET_W;
  localparam int TAG_W    = 4;
  localparam int TAG_LSB  = 6;

  // write with this bit set is a line fill
  localparam int FILL_BIT = 10;

  typedef enum logic [1:0] {
    op_read,
    op_write,
    op_fill
  } cache_op_e;

  typedef enum logic [1:0] {
    ph_idle,
    ph_issued, // op_valid cycle
    ph_wait
  } apb_phase_e;

endpackage

// ==== logic/cache_top.sv ====
`timescale 1ns/10ps

module cache_top
  import cache_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [PADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0]  pwdata,
  input  logic [STRB_W-1:0]  pstrb,
  output logic [DATA_W-1:0]  prdata,
  output logic               pready,
  output logic               pslverr
);

  localparam int RANK_W = $clog2(NUM_WAYS);

  // decoder broadcast
  logic              op_valid;
  cache_op_e         op;
  logic [SET_W-1:0]  set_idx;
  logic [TAG_W-1:0]  tag;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] strb;

  // way results, packed per way
  logic [NUM_WAYS-1:0]        way_hit;
  logic [NUM_WAYS*RANK_W-1:0] way_rank;
  logic [NUM_WAYS*DATA_W-1:0] way_rdata;

  // update back to the ways
  logic              touch_en;
  logic [RANK_W-1:0] touch_rank;
  cache_op_e         commit_op;

  apb_req_decoder dec_mod (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pstrb    (pstrb),
    .pready   (pready),
    .op_valid (op_valid),
    .op       (op),
    .set_idx  (set_idx),
    .tag      (tag),
    .wdata    (wdata),
    .strb     (strb)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : way_gen
    cache_way #(
      .NUM_WAYS (NUM_WAYS),
      .WAY_ID   (w)
    ) way_mod (
      .clk        (clk),
      .rst        (rst),
      .op_valid   (op_valid),
      .op         (op),
      .set_idx    (set_idx),
      .tag        (tag),
      .wdata      (wdata),
      .strb       (strb),
      .touch_en   (touch_en),
      .touch_rank (touch_rank),
      .commit_op  (commit_op),
      .hit        (way_hit[w]),
      .rank       (way_rank[w*RANK_W +: RANK_W]),
      .rdata      (way_rdata[w*DATA_W +: DATA_W])
    );
  end

  hit_merge #(
    .NUM_WAYS (NUM_WAYS)
  ) merge_mod (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .op         (op),
    .hit        (way_hit),
    .rank       (way_rank),
    .rdata      (way_rdata),
    .touch_en   (touch_en),
    .touch_rank (touch_rank),
    .commit_op  (commit_op),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

endmodule

// ==== logic/cache_way.sv ====
`timescale 1ns/10ps

module cache_way
  import cache_pkg::*;
#(
  parameter int NUM_WAYS = 4,
  parameter int WAY_ID   = 0
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        op_valid,
  input  cache_op_e                   op,
  input  logic [SET_W-1:0]            set_idx,
  input  logic [TAG_W-1:0]            tag,
  input  logic [DATA_W-1:0]           wdata,
  input  logic [STRB_W-1:0]           strb,
  input  logic                        touch_en,
  input  logic [$clog2(NUM_WAYS)-1:0] touch_rank,
  input  cache_op_e                   commit_op,
  output logic                        hit,
  output logic [$clog2(NUM_WAYS)-1:0] rank,
  output logic [DATA_W-1:0]           rdata
);

  localparam int RANK_W = $clog2(NUM_WAYS);

  logic [NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_mem  [0:NUM_SETS-1];
  logic [DATA_W-1:0]   data_mem [0:NUM_SETS-1];
  logic [RANK_W-1:0]   rank_q   [0:NUM_SETS-1];

  logic                lookup_hit;
  logic                selected;
  logic [DATA_W-1:0]   merged;

  assign lookup_hit = valid_q[set_idx] && (tag_mem[set_idx] == tag);

  // rank register holds this set's rank from the lookup
  assign selected = touch_en && (rank == touch_rank);

  // byte merge for write hits
  always_comb begin
    merged = data_mem[set_idx];
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) merged[8*b +: 8] = wdata[8*b +: 8];
    end
  end

  // lookup result
  always_ff @(posedge clk) begin
    if (rst) begin
      hit <= 1'b0;
    end else if (op_valid) begin
      hit <= lookup_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (op_valid) begin
      rank  <= rank_q[set_idx];
      // zero on anything but a read hit lets the merge OR all ways
      rdata <= (lookup_hit && op == op_read) ? data_mem[set_idx] : '0;
    end
  end

  // valid and LRU rank
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      for (int s = 0; s < NUM_SETS; s++) begin
        rank_q[s] <= RANK_W'(WAY_ID);
      end
    end else if (touch_en) begin
      if (selected) begin
        rank_q[set_idx] <= '0; // most recently used
        if (commit_op == op_fill) valid_q[set_idx] <= 1'b1;
      end else if (rank < touch_rank) begin
        rank_q[set_idx] <= rank + 1'b1;
      end
    end
  end

  // tag and data storage
  always_ff @(posedge clk) begin
    if (selected) begin
      case (commit_op)
        op_write: begin
          data_mem[set_idx] <= merged;
        end
        op_fill: begin
          data_mem[set_idx] <= wdata;
          tag_mem[set_idx]  <= tag;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== logic/hit_merge.sv ====
`timescale 1ns/10ps

module hit_merge
  import cache_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 op_valid,
  input  cache_op_e                            op,
  input  logic [NUM_WAYS-1:0]                  hit,
  input  logic [NUM_WAYS*$clog2(NUM_WAYS)-1:0] rank,
  input  logic [NUM_WAYS*DATA_W-1:0]           rdata,
  output logic                                 touch_en,
  output logic [$clog2(NUM_WAYS)-1:0]          touch_rank,
  output cache_op_e                            commit_op,
  output logic [DATA_W-1:0]                    prdata,
  output logic                                 pready,
  output logic                                 pslverr
);

  localparam int RANK_W = $clog2(NUM_WAYS);
  localparam logic [RANK_W-1:0] RANK_MAX = RANK_W'(NUM_WAYS - 1);

  logic              res_valid; // way outputs hold this op's lookup
  logic              any_hit;
  logic [RANK_W-1:0] hit_rank;
  logic [DATA_W-1:0] rdata_or;
  logic              miss_err;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= op_valid;
    end
  end

  always_comb begin
    any_hit  = |hit;
    hit_rank = '0;
    rdata_or = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      rdata_or = rdata_or | rdata[w*DATA_W +: DATA_W];
      if (hit[w]) hit_rank = hit_rank | rank[w*RANK_W +: RANK_W];
    end
  end

  // fill miss evicts the oldest way
  assign touch_en   = res_valid && (any_hit || op == op_fill);
  assign touch_rank = any_hit ? hit_rank : RANK_MAX;
  assign commit_op  = op;

  assign miss_err = !any_hit && (op != op_fill);

  always_ff @(posedge clk) begin
    if (rst) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= res_valid;
      pslverr <= res_valid && miss_err;
    end
  end

  // read data only on a read hit, zero otherwise
  always_ff @(posedge clk) begin
    prdata <= (res_valid && op == op_read && any_hit) ? rdata_or : '0;
  end

endmodule

// ==== sim.f ====
logic/cache_pkg.sv
logic/apb_req_decoder.sv
logic/cache_way.sv
logic/hit_merge.sv
logic/cache_top.sv
tests/cache_checker.sv
tests/tb_cache_top.sv

// ==== tests/cache_checker.sv ====
`timescale 1ns/10ps

module cache_checker
  import cache_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [PADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0]  pwdata,
  input  logic [STRB_W-1:0]  pstrb,
  input  logic [DATA_W-1:0]  prdata,
  input  logic               pready,
  input  logic               pslverr,
  output int                 value_errs,
  output int                 timing_errs,
  output int                 resp_cnt
);

  // reference cache, 16 sets by NUM_WAYS ways
  logic        m_valid [16][NUM_WAYS];
  logic [3:0]  m_tag   [16][NUM_WAYS];
  logic [31:0] m_data  [16][NUM_WAYS];
  int          m_rank  [16][NUM_WAYS];
  int          acc_cnt; // access cycles seen in the current transfer

  task automatic clear_model();
    for (int s = 0; s < 16; s++) begin
      for (int k = 0; k < NUM_WAYS; k++) begin
        m_valid[s][k] = 1'b0;
        m_rank[s][k]  = k;
      end
    end
  endtask

  // touched way goes to 0, younger ways age by one
  task automatic touch_way(input int s, input int w);
    int r;
    r = m_rank[s][w];
    for (int k = 0; k < NUM_WAYS; k++) begin
      if (m_rank[s][k] == r) m_rank[s][k] = 0;
      else if (m_rank[s][k] < r) m_rank[s][k]++;
    end
  endtask

  task automatic check_response();
    int          s;
    int          w;
    int          hw;
    logic [3:0]  t;
    logic [31:0] exp_data;
    logic        exp_err;
    s = paddr[5:2];
    t = paddr[9:6];
    hw = -1;
    exp_data = '0;
    exp_err = 1'b0;
    for (int k = 0; k < NUM_WAYS; k++) begin
      if (m_valid[s][k] && m_tag[s][k] == t) hw = k;
    end
    if (pwrite && paddr[10]) begin
      w = hw;
      if (hw < 0) begin
        for (int k = 0; k < NUM_WAYS; k++) begin
          if (m_rank[s][k] == NUM_WAYS - 1) w = k; // oldest line is the victim
        end
      end
      m_valid[s][w] = 1'b1;
      m_tag[s][w]   = t;
      m_data[s][w]  = pwdata;
      touch_way(s, w);
    end else if (hw < 0) begin
      exp_err = 1'b1; // miss leaves the cache alone
    end else if (pwrite) begin
      for (int b = 0; b < 4; b++) begin
        if (pstrb[b]) m_data[s][hw][8*b +: 8] = pwdata[8*b +: 8];
      end
      touch_way(s, hw);
    end else begin
      exp_data = m_data[s][hw];
      touch_way(s, hw);
    end
    if (prdata !== exp_data) begin
      value_errs++;
      $display("ERR %0t prdata expected %h got %h", $time, exp_data, prdata);
    end
    if (pslverr !== exp_err) begin
      value_errs++;
      $display("ERR %0t pslverr expected %b got %b", $time, exp_err, pslverr);
    end
    resp_cnt++;
  endtask

  // samples the values held through the cycle that just ended
  always @(posedge clk) begin
    if (rst) begin
      clear_model();
      acc_cnt = 0;
    end else begin
      if (psel && penable) acc_cnt++;
      if (pready) begin
        if (!(psel && penable)) begin
          timing_errs++;
          $display("pready was high outside an access phase at %0t", $time);
        end else begin
          if (acc_cnt != 4) begin
            timing_errs++;
            $display("pready came in access cycle %0d instead of 4 at %0t", acc_cnt, $time);
          end
          check_response();
        end
        acc_cnt = 0;
      end else begin
        if (pslverr) begin
          timing_errs++;
          $display("pslverr was high without pready at %0t", $time);
        end
        if (acc_cnt == 5) begin
          timing_errs++;
          $display("no pready after four access cycles at %0t", $time);
        end
      end
    end
  end

endmodule

// ==== tests/tb_cache_top.sv ====
`timescale 1ns/10ps

module tb_cache_top
  import cache_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_WAYS   = 4;
  localparam int N_RAND     = 400;
  localparam int N_XFERS    = N_RAND + 40; // directed part stays under 40
  localparam int TIMEOUT_NS = (N_XFERS * 8 + 8 + 50) * CLK_PERIOD;

  logic               clk;
  logic               rst;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [PADDR_W-1:0] paddr;
  logic [DATA_W-1:0]  pwdata;
  logic [STRB_W-1:0]  pstrb;
  logic [DATA_W-1:0]  prdata;
  logic               pready;
  logic               pslverr;

  logic [19:0] lfsr_q;
  int          issued;
  int          value_errs;
  int          timing_errs;
  int          resp_cnt;

  cache_top #(
    .NUM_WAYS (NUM_WAYS)
  ) dut0 (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  cache_checker #(
    .NUM_WAYS (NUM_WAYS)
  ) chk0 (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .value_errs  (value_errs),
    .timing_errs (timing_errs),
    .resp_cnt    (resp_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^20 + x^17 + 1
  function automatic logic [19:0] lfsr_next(input logic [19:0] s);
    return {s[18:0], s[19] ^ s[16]};
  endfunction

  task automatic draw(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [PADDR_W-1:0] make_addr(input logic [3:0] tag, input logic [3:0] set,
                                                   input logic fill);
    return {1'b0, fill, tag, set, 2'b00};
  endfunction

  // setup, access, then hold until pready
  task automatic apb_xfer(input logic wr, input logic [PADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] be);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    pstrb   <= be;
    @(posedge clk);
    penable <= 1'b1;
    do @(posedge clk); while (!pready);
    psel    <= 1'b0;
    penable <= 1'b0;
    issued++;
  endtask

  task automatic read_word(input logic [3:0] tag, input logic [3:0] set);
    apb_xfer(1'b0, make_addr(tag, set, 1'b0), 32'h0, 4'h0);
  endtask

  task automatic write_word(input logic [3:0] tag, input logic [3:0] set,
                            input logic [31:0] data, input logic [3:0] be);
    apb_xfer(1'b1, make_addr(tag, set, 1'b0), data, be);
  endtask

  task automatic fill_word(input logic [3:0] tag, input logic [3:0] set, input logic [31:0] data);
    apb_xfer(1'b1, make_addr(tag, set, 1'b1), data, 4'hf);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] kind;
    logic [31:0] tg;
    logic [31:0] st;
    logic [31:0] be;
    logic [31:0] dat;
    logic [31:0] fb;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    lfsr_q  = 20'd81060;
    issued  = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // every read misses in an empty cache
    for (int i = 0; i < 4; i++) read_word(4'(i + 3), 4'(i * 5));

    // fill, read back, refill of a hitting line
    fill_word(4'd2, 4'd1, 32'hcafe_0001);
    read_word(4'd2, 4'd1);
    fill_word(4'd2, 4'd1, 32'h1234_5678);
    read_word(4'd2, 4'd1);

    // byte strobes, then a write miss
    write_word(4'd2, 4'd1, 32'haabb_ccdd, 4'b0101);
    read_word(4'd2, 4'd1);
    write_word(4'd6, 4'd1, 32'hffff_ffff, 4'hf);
    read_word(4'd6, 4'd1);
    read_word(4'd2, 4'd1);

    // refreshed tag 1 survives the first eviction
    for (int t = 1; t <= 4; t++) fill_word(4'(t), 4'd5, 32'h5500_0000 + t);
    read_word(4'd1, 4'd5);
    fill_word(4'd5, 4'd5, 32'h5500_0005);
    for (int t = 1; t <= 5; t++) read_word(4'(t), 4'd5);
    fill_word(4'd6, 4'd5, 32'h5500_0006); // read order left tag 1 oldest
    read_word(4'd1, 4'd5);

    // random mix over a few sets and tags
    for (int i = 0; i < N_RAND; i++) begin
      draw(2, kind);
      draw(3, tg);
      draw(2, st);
      draw(4, be);
      draw(32, dat);
      draw(1, fb);
      case (kind[1:0])
        2'd2: write_word(tg[3:0], st[3:0], dat, be[3:0]);
        2'd3: fill_word(tg[3:0], st[3:0], dat);
        default: apb_xfer(1'b0, make_addr(tg[3:0], st[3:0], fb[0]), dat, be[3:0]);
      endcase
    end

    repeat (4) @(posedge clk);
    $display("value errors %0d, timing faults %0d, responses %0d of %0d",
             value_errs, timing_errs, resp_cnt, issued);
    if (value_errs == 0 && timing_errs == 0 && resp_cnt == issued) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
